/* include/refill_defines.svh */
`ifndef REFILL_DEFINES_SVH
`define REFILL_DEFINES_SVH

// bus and data widths
`define REFILL_ADDR_W          32
`define REFILL_DATA_W          32

// address split: tag | set | byte offset within the line
`define REFILL_TAG_W           21
`define REFILL_SET_W           5
`define REFILL_OFFSET_W        6
`define REFILL_WAY_W           2   // four ways per set

`define REFILL_LINE_WORDS      16  // 64-byte line of 32-bit words
`define REFILL_BURST_W         5   // wide enough to carry a count of 16

`define REFILL_CMD_FIFO_DEPTH  2

// tag-RAM word layout, tag in the low bits and zeros above the dirty bit
`define REFILL_TAG_VALID_BIT   21
`define REFILL_TAG_DIRTY_BIT   22

// packed bus command: address, byte enables, read, write, write data,
// begin-burst flag and burst count
`define REFILL_CMD_W (`REFILL_ADDR_W + `REFILL_DATA_W / 8 + 2 + `REFILL_DATA_W + 1 + \
                      `REFILL_BURST_W)

`endif

/* refill.f */
+incdir+include
source/refill_pkg.sv
source/bus_cmd_fifo.sv
source/victim_select.sv
source/refill_fsm.sv
source/refill_top.sv
verification/refill_props.sv
verification/refill_tb.sv

/* run_sim.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal --top-module refill_tb -f refill.f
./obj_dir/Vrefill_tb | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log || ! grep -q "Simulation finished: PASS" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

/* source/bus_cmd_fifo.sv */
`default_nettype none

module bus_cmd_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 2
) (
  input  logic             clk,
  input  logic             rest,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  input  logic             pop,
  output logic [WIDTH-1:0] head_data,
  output logic             full,
  output logic             empty
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             bypass;
  logic             do_push;
  logic             do_pop;

  // pointers wrap by compare so any depth works, not only powers of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));

  // a word pushed into an empty buffer and taken in the same cycle never gets stored
  assign bypass  = empty && push && pop;
  assign do_push = push && !full && !bypass;
  assign do_pop  = pop && !empty;  // pop on an empty buffer does nothing

  // head shows zero when nothing is queued, so no command appears on the bus
  assign head_data = !empty ? mem[rd_ptr] : (push ? push_data : '0);

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

endmodule

`default_nettype wire

/* source/refill_fsm.sv */
`default_nettype none

`include "refill_defines.svh"

module refill_fsm (
  input  logic                       clk,
  input  logic                       rest,
  input  refill_pkg::req_op_t        req_op,
  input  refill_pkg::addr_t          req_address,
  input  refill_pkg::word_t          req_wdata,
  input  refill_pkg::byte_en_t       req_byte_en,
  input  logic                       req_read,
  output logic                       req_ready,
  output refill_pkg::word_t          rsp_data,
  output refill_pkg::set_t           set_index,
  input  refill_pkg::way_t           victim_way,
  output logic                       fill_start,
  output logic                       cmd_push,
  output logic [`REFILL_CMD_W-1:0]   cmd_word,
  input  logic                       cmd_full,
  input  logic                       cmd_empty,
  input  logic                       bus_wait,
  input  logic                       bus_read_head,
  input  logic                       bus_write_head,
  input  refill_pkg::word_t          bus_rdata,
  input  logic                       bus_rdata_valid,
  output refill_pkg::data_ram_addr_t data_ram_addr,
  output refill_pkg::way_t           data_ram_way,
  input  refill_pkg::word_t          data_ram_rdata,
  output logic                       data_ram_we,
  output refill_pkg::word_t          data_ram_wdata,
  output refill_pkg::set_t           tag_ram_set,
  output refill_pkg::way_t           tag_ram_way,
  input  refill_pkg::word_t          tag_ram_rdata,
  output logic                       tag_ram_we,
  output refill_pkg::word_t          tag_ram_wdata
);

  import refill_pkg::*;

  localparam int SET_LO = `REFILL_OFFSET_W;
  localparam int TAG_LO = `REFILL_OFFSET_W + `REFILL_SET_W;
  localparam int INIT_W = `REFILL_SET_W + `REFILL_WAY_W + 1;  // top bit flags the end of init
  localparam int BYTE_OFS_W = `REFILL_OFFSET_W - $bits(word_index_t);
  localparam burst_t LINE_BURST = burst_t'(`REFILL_LINE_WORDS);

  refill_state_t     state;
  addr_t             fill_addr;
  way_t              fill_way;
  tag_t              victim_tag;
  set_t              fill_set;
  tag_t              fill_tag;
  burst_t            rd_cnt;     // data-RAM reads issued during write-back
  burst_t            push_cnt;   // write commands pushed
  word_index_t       acc_cnt;    // write commands taken by the bus
  word_index_t       rx_cnt;     // read beats received
  word_index_t       wb_index;
  logic              rd_valid;   // data_ram_rdata holds the word at push_cnt
  logic              rd_issued;
  logic [INIT_W-1:0] init_cnt;
  logic              victim_dirty;
  logic              io_push;
  logic              wb_push;
  logic              wb_read;
  logic              wb_accept;
  logic              rd_push;
  logic              beat;

  function automatic addr_t word_addr(input tag_t tag, input set_t set_idx,
                                      input word_index_t index);
    return {tag, set_idx, index, {BYTE_OFS_W{1'b0}}};
  endfunction

  assign fill_set  = fill_addr[TAG_LO-1:SET_LO];
  assign fill_tag  = fill_addr[`REFILL_ADDR_W-1:TAG_LO];
  assign set_index = req_address[TAG_LO-1:SET_LO];

  // only a line that is both valid and modified goes back to memory
  assign victim_dirty = tag_ram_rdata[`REFILL_TAG_VALID_BIT] &&
                        tag_ram_rdata[`REFILL_TAG_DIRTY_BIT];

  assign fill_start = (state == state_idle) && (req_op == op_fill);
  assign io_push    = (state == state_idle) && (req_op == op_io);

  // write-back pipeline: RAM read, then push the word one cycle later
  assign wb_push   = (state == state_write_back) && rd_valid && !cmd_full;
  assign wb_read   = (state == state_write_back) && (rd_cnt < LINE_BURST) &&
                     (!rd_valid || wb_push);
  assign wb_accept = (state == state_write_back) && bus_write_head && !bus_wait;

  // the read command waits for an empty FIFO so it is pushed exactly once
  assign rd_push = (state == state_read_in) && !rd_issued && cmd_empty;
  assign beat    = (state == state_read_in) && bus_rdata_valid;

  assign cmd_push = io_push || wb_push || rd_push;

  assign req_ready = (state == state_settle) ||
                     ((state == state_io_wait) && (req_read ? bus_rdata_valid : cmd_empty));
  assign rsp_data  = bus_rdata;

  // while a push is stalled the RAM keeps re-reading the pending word
  assign wb_index = (rd_valid && !wb_push) ? word_index_t'(push_cnt) : word_index_t'(rd_cnt);

  always_comb begin
    cmd_word = '0;
    if (io_push) begin
      cmd_word = {req_address, req_byte_en, req_read, !req_read, req_wdata,
                  1'b0, burst_t'(1)};
    end else if (wb_push) begin
      cmd_word = {word_addr(victim_tag, fill_set, word_index_t'(push_cnt)), byte_en_t'('1),
                  1'b0, 1'b1, data_ram_rdata, push_cnt == '0, LINE_BURST};
    end else if (rd_push) begin
      cmd_word = {word_addr(fill_tag, fill_set, '0), byte_en_t'('1),
                  1'b1, 1'b0, word_t'('0), 1'b1, LINE_BURST};
    end
  end

  assign data_ram_way   = fill_way;
  assign data_ram_addr  = (state == state_write_back) ? {fill_set, wb_index} : {fill_set, rx_cnt};
  assign data_ram_we    = beat;       // each beat goes straight into the line
  assign data_ram_wdata = bus_rdata;

  always_comb begin
    case (state)
      state_init: begin
        tag_ram_set = init_cnt[`REFILL_SET_W-1:0];
        tag_ram_way = init_cnt[`REFILL_SET_W+`REFILL_WAY_W-1:`REFILL_SET_W];
      end
      state_idle: begin  // look up the victim so its tag is ready next cycle
        tag_ram_set = set_index;
        tag_ram_way = victim_way;
      end
      default: begin
        tag_ram_set = fill_set;
        tag_ram_way = fill_way;
      end
    endcase
  end

  assign tag_ram_we = (beat && (rx_cnt == '0)) ||
                      ((state == state_init) && !init_cnt[INIT_W-1]);

  always_comb begin
    tag_ram_wdata = '0;  // init clears the whole entry
    if (state == state_read_in) begin
      tag_ram_wdata[`REFILL_TAG_W-1:0]     = fill_tag;
      tag_ram_wdata[`REFILL_TAG_VALID_BIT] = 1'b1;  // new line is valid and clean
    end
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      state     <= state_idle;
      rd_cnt    <= '0;
      push_cnt  <= '0;
      acc_cnt   <= '0;
      rx_cnt    <= '0;
      rd_valid  <= 1'b0;
      rd_issued <= 1'b0;
      init_cnt  <= '0;
    end else begin
      case (state)
        state_idle: begin
          init_cnt <= '0;
          case (req_op)
            op_io:   state <= state_io_wait;
            op_fill: state <= state_victim_check;
            op_init: state <= state_init;
            default: state <= state_idle;
          endcase
        end
        state_io_wait: begin
          if (req_ready) state <= state_idle;
        end
        state_victim_check: begin
          rd_cnt    <= '0;
          push_cnt  <= '0;
          acc_cnt   <= '0;
          rx_cnt    <= '0;
          rd_valid  <= 1'b0;
          rd_issued <= 1'b0;
          state     <= victim_dirty ? state_write_back : state_read_in;
        end
        state_write_back: begin
          if (wb_read) rd_cnt <= rd_cnt + 1'b1;
          if (wb_push) push_cnt <= push_cnt + 1'b1;
          rd_valid <= wb_read || (rd_valid && !wb_push);
          if (wb_accept) begin
            acc_cnt <= acc_cnt + 1'b1;
            // last write taken means the FIFO is drained as well
            if (acc_cnt == '1) state <= state_read_in;
          end
        end
        state_read_in: begin
          if (bus_read_head && !bus_wait) rd_issued <= 1'b1;
          if (beat) begin
            rx_cnt <= rx_cnt + 1'b1;
            if (rx_cnt == '1) state <= state_settle;
          end
        end
        state_settle: begin
          state <= state_idle;
        end
        state_init: begin
          init_cnt <= init_cnt + 1'b1;
          if (init_cnt[INIT_W-1]) state <= state_settle;  // one idle cycle after entry 127
        end
        default: begin
          state <= state_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fill_start) begin
      fill_addr <= req_address;
      fill_way  <= victim_way;
    end
    if (state == state_victim_check) victim_tag <= tag_ram_rdata[`REFILL_TAG_W-1:0];
  end

endmodule

`default_nettype wire

/* source/refill_pkg.sv */
`default_nettype none

`include "refill_defines.svh"

package refill_pkg;

  typedef logic [`REFILL_ADDR_W-1:0]     addr_t;     // byte address
  typedef logic [`REFILL_DATA_W-1:0]     word_t;     // data word, also a tag-RAM word
  typedef logic [`REFILL_DATA_W/8-1:0]   byte_en_t;
  typedef logic [`REFILL_TAG_W-1:0]      tag_t;
  typedef logic [`REFILL_SET_W-1:0]      set_t;
  typedef logic [`REFILL_WAY_W-1:0]      way_t;

  // word within a line, the two byte-offset bits are dropped
  typedef logic [`REFILL_OFFSET_W-3:0]   word_index_t;

  // data RAM is addressed per way by set and word index
  typedef logic [`REFILL_SET_W+`REFILL_OFFSET_W-3:0] data_ram_addr_t;

  typedef logic [`REFILL_BURST_W-1:0]    burst_t;

  typedef enum logic [1:0] {
    op_none,
    op_io,    // single uncached read or write
    op_fill,  // line refill after a miss
    op_init   // clear every tag entry
  } req_op_t;

  typedef enum logic [2:0] {
    state_idle,
    state_io_wait,
    state_victim_check,
    state_write_back,
    state_read_in,
    state_settle,
    state_init
  } refill_state_t;

endpackage

`default_nettype wire

/* source/refill_top.sv */
`default_nettype none

`include "refill_defines.svh"

module refill_top (
  input  logic                       clk,
  input  logic                       rest,
  input  refill_pkg::req_op_t        req_op,
  input  refill_pkg::addr_t          req_address,
  input  refill_pkg::word_t          req_wdata,
  input  refill_pkg::byte_en_t       req_byte_en,
  input  logic                       req_read,
  input  logic                       free_valid,
  input  refill_pkg::way_t           free_way,
  output logic                       req_ready,
  output refill_pkg::word_t          rsp_data,
  output refill_pkg::addr_t          bus_address,
  output refill_pkg::byte_en_t       bus_byte_en,
  output logic                       bus_read,
  output logic                       bus_write,
  output refill_pkg::word_t          bus_wdata,
  input  logic                       bus_wait,
  output logic                       bus_begin_burst,
  output refill_pkg::burst_t         bus_burst_count,
  input  refill_pkg::word_t          bus_rdata,
  input  logic                       bus_rdata_valid,
  output refill_pkg::data_ram_addr_t data_ram_addr,
  output refill_pkg::way_t           data_ram_way,
  input  refill_pkg::word_t          data_ram_rdata,
  output logic                       data_ram_we,
  output refill_pkg::word_t          data_ram_wdata,
  output refill_pkg::set_t           tag_ram_set,
  output refill_pkg::way_t           tag_ram_way,
  input  refill_pkg::word_t          tag_ram_rdata,
  output logic                       tag_ram_we,
  output refill_pkg::word_t          tag_ram_wdata
);

  import refill_pkg::*;

  set_t                     set_index;
  way_t                     victim_way;
  logic                     fill_start;
  logic                     cmd_push;
  logic [`REFILL_CMD_W-1:0] cmd_word;
  logic [`REFILL_CMD_W-1:0] cmd_head;
  logic                     cmd_full;
  logic                     cmd_empty;
  logic                     cmd_pop;

  // field order has to match the packing in refill_fsm
  assign {bus_address, bus_byte_en, bus_read, bus_write, bus_wdata,
          bus_begin_burst, bus_burst_count} = cmd_head;

  assign cmd_pop = (bus_read || bus_write) && !bus_wait;  // command taken by the bus

  refill_fsm u_fsm (
    .clk             (clk),
    .rest            (rest),
    .req_op          (req_op),
    .req_address     (req_address),
    .req_wdata       (req_wdata),
    .req_byte_en     (req_byte_en),
    .req_read        (req_read),
    .req_ready       (req_ready),
    .rsp_data        (rsp_data),
    .set_index       (set_index),
    .victim_way      (victim_way),
    .fill_start      (fill_start),
    .cmd_push        (cmd_push),
    .cmd_word        (cmd_word),
    .cmd_full        (cmd_full),
    .cmd_empty       (cmd_empty),
    .bus_wait        (bus_wait),
    .bus_read_head   (bus_read),
    .bus_write_head  (bus_write),
    .bus_rdata       (bus_rdata),
    .bus_rdata_valid (bus_rdata_valid),
    .data_ram_addr   (data_ram_addr),
    .data_ram_way    (data_ram_way),
    .data_ram_rdata  (data_ram_rdata),
    .data_ram_we     (data_ram_we),
    .data_ram_wdata  (data_ram_wdata),
    .tag_ram_set     (tag_ram_set),
    .tag_ram_way     (tag_ram_way),
    .tag_ram_rdata   (tag_ram_rdata),
    .tag_ram_we      (tag_ram_we),
    .tag_ram_wdata   (tag_ram_wdata)
  );

  victim_select u_victim (
    .clk        (clk),
    .rest       (rest),
    .set_index  (set_index),
    .free_valid (free_valid),
    .free_way   (free_way),
    .fill_start (fill_start),
    .way        (victim_way)
  );

  bus_cmd_fifo #(
    .WIDTH (`REFILL_CMD_W),
    .DEPTH (`REFILL_CMD_FIFO_DEPTH)
  ) u_cmd_fifo (
    .clk       (clk),
    .rest      (rest),
    .push      (cmd_push),
    .push_data (cmd_word),
    .pop       (cmd_pop),
    .head_data (cmd_head),
    .full      (cmd_full),
    .empty     (cmd_empty)
  );

endmodule

`default_nettype wire

/* source/victim_select.sv */
`default_nettype none

module victim_select (
  input  logic             clk,
  input  logic             rest,
  input  refill_pkg::set_t set_index,
  input  logic             free_valid,
  input  refill_pkg::way_t free_way,
  input  logic             fill_start,
  output refill_pkg::way_t way
);

  import refill_pkg::*;

  localparam int SETS = 2 ** $bits(set_t);

  // one round-robin pointer per set, it names the next way to evict
  way_t rr_count [SETS];

  // a free way always wins over eviction
  assign way = free_valid ? free_way : rr_count[set_index];

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      for (int i = 0; i < SETS; i++) begin
        rr_count[i] <= '0;
      end
    end else if (fill_start && !free_valid) begin
      rr_count[set_index] <= rr_count[set_index] + 1'b1;  // wraps from 3 back to 0
    end
  end

endmodule

`default_nettype wire

/* verification/refill_props.sv */
`default_nettype none

module refill_props (
  input logic        clk,
  input logic        rest,
  input logic        req_ready,
  input logic [31:0] bus_address,
  input logic [3:0]  bus_byte_en,
  input logic        bus_read,
  input logic        bus_write,
  input logic [31:0] bus_wdata,
  input logic        bus_wait,
  input logic        bus_begin_burst,
  input logic [4:0]  bus_burst_count,
  input logic        data_ram_we,
  input logic        tag_ram_we
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [75:0] bus_cmd;

  assign bus_cmd = {bus_address, bus_byte_en, bus_read, bus_write, bus_wdata,
                    bus_begin_burst, bus_burst_count};

  read_write_exclusive: assert property (@(posedge clk) disable iff (!rest)
    !(bus_read && bus_write)) else $error("bus read and write high together");

  // a stalled command must wait unchanged until the bus takes it
  command_held: assert property (@(posedge clk) disable iff (!rest)
    (bus_read || bus_write) && bus_wait |=> $stable(bus_cmd))
    else $error("bus command changed under wait");

  ready_pulse: assert property (@(posedge clk) disable iff (!rest)
    req_ready |=> !req_ready) else $error("req_ready longer than one cycle");

  quiet_in_reset: assert property (@(posedge clk)
    !rest |-> !(req_ready || bus_read || bus_write || data_ram_we || tag_ram_we))
    else $error("activity during reset");

endmodule

bind refill_top refill_props u_props (.*);

`default_nettype wire

/* verification/refill_tb.sv */
`default_nettype none

`include "refill_defines.svh"

module refill_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import refill_pkg::*;

  localparam int ROWS = 11;
  localparam int LINE = `REFILL_LINE_WORDS;

  typedef struct packed {
    req_op_t op;
    addr_t   address;
    word_t   wdata;
    logic    read;
    logic    free_valid;
    way_t    free_way;
    logic    preset;       // victim tag is loaded valid and dirty before the request
    tag_t    preset_tag;
    way_t    exp_way;
    word_t   exp_data;
  } row_t;

  logic           clk = 1'b0;
  logic           rest = 1'b0;
  req_op_t        req_op = op_none;
  addr_t          req_address = '0;
  word_t          req_wdata = '0;
  byte_en_t       req_byte_en = '1;
  logic           req_read = 1'b0;
  logic           free_valid = 1'b0;
  way_t           free_way = '0;
  logic           req_ready;
  word_t          rsp_data;
  addr_t          bus_address;
  byte_en_t       bus_byte_en;
  logic           bus_read;
  logic           bus_write;
  word_t          bus_wdata;
  logic           bus_wait = 1'b0;
  logic           bus_begin_burst;
  burst_t         bus_burst_count;
  word_t          bus_rdata = '0;
  logic           bus_rdata_valid = 1'b0;
  data_ram_addr_t data_ram_addr;
  way_t           data_ram_way;
  word_t          data_ram_rdata = '0;
  logic           data_ram_we;
  word_t          data_ram_wdata;
  set_t           tag_ram_set;
  way_t           tag_ram_way;
  word_t          tag_ram_rdata = '0;
  logic           tag_ram_we;
  word_t          tag_ram_wdata;

  word_t  mem [4096];
  word_t  data_mem [4][512];
  word_t  tag_mem [4][32];
  row_t   rows [ROWS];
  integer seed = 32'h0d033efb;
  int     rd_left = 0;
  logic [11:0] rd_addr = '0;
  int     we_count;
  int     wr_count;
  int     burst_starts;  // write commands taken with the begin-burst flag
  int     start_pos;     // write number that carried the flag
  way_t   seen_way;
  logic   way_mixed;
  int     errors = 0;
  int     passed = 0;
  logic   timed_out = 1'b0;

  refill_top uut (.*);

  always #50 clk = ~clk;

  function automatic word_t pattern(input int word_address);
    return word_t'(word_address * 3 + 1);
  endfunction

  // memory and RAM models sample the DUT on the rising edge, like the flops they stand for
  always @(posedge clk) begin
    if (bus_rdata_valid) begin
      rd_left = rd_left - 1;
      rd_addr = rd_addr + 1'b1;
    end
    if ((bus_read || bus_write) && !bus_wait) begin
      if (bus_read) begin
        rd_addr = bus_address[13:2];
        rd_left = int'(bus_burst_count);
      end else begin
        for (int b = 0; b < 4; b++) begin
          if (bus_byte_en[b]) mem[bus_address[13:2]][b*8 +: 8] = bus_wdata[b*8 +: 8];
        end
        if (bus_begin_burst) begin
          burst_starts++;
          start_pos = wr_count;
        end
        wr_count++;
      end
    end
    if (data_ram_we) begin
      if (we_count != 0 && data_ram_way != seen_way) way_mixed = 1'b1;
      seen_way = data_ram_way;
      we_count++;
    end
    data_ram_rdata <= data_mem[data_ram_way][data_ram_addr];  // read before write
    tag_ram_rdata  <= tag_mem[tag_ram_way][tag_ram_set];
    if (data_ram_we) data_mem[data_ram_way][data_ram_addr] <= data_ram_wdata;
    if (tag_ram_we) tag_mem[tag_ram_way][tag_ram_set] <= tag_ram_wdata;
  end

  always @(negedge clk) begin
    if (rest) bus_wait = (($random(seed) & 3) == 0);  // about one cycle in four stalls
    bus_rdata_valid = (rd_left != 0);
    bus_rdata = mem[rd_addr];
  end

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_way(input way_t got, input way_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t: %s got way %0d expected way %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_tag(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t: %s tag word %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic wait_ready(input int limit, output int cycles);
    cycles = 0;
    #10;
    while (!req_ready && cycles < limit) begin
      @(negedge clk);
      #10;
      cycles++;
    end
    if (!req_ready) timed_out = 1'b1;
  endtask

  function automatic addr_t line_addr(input tag_t tag, input set_t set_idx);
    return {tag, set_idx, 6'b0};
  endfunction

  initial begin
    rows[0]  = '{op_init, '0, '0, 1'b0, 1'b0, 2'd0, 1'b0, '0, 2'd0, '0};
    rows[1]  = '{op_io, 32'h100, 32'hcafe0001, 1'b0, 1'b0, 2'd0, 1'b0, '0, 2'd0, 32'hcafe0001};
    rows[2]  = '{op_io, 32'h100, '0, 1'b1, 1'b0, 2'd0, 1'b0, '0, 2'd0, 32'hcafe0001};
    rows[3]  = '{op_fill, line_addr(5, 3), '0, 1'b0, 1'b1, 2'd2, 1'b0, '0, 2'd2, '0};
    rows[4]  = '{op_fill, line_addr(2, 7), '0, 1'b0, 1'b1, 2'd1, 1'b1, 21'd6, 2'd1, '0};
    rows[5]  = '{op_fill, line_addr(1, 12), '0, 1'b0, 1'b0, 2'd3, 1'b0, '0, 2'd0, '0};
    rows[6]  = '{op_fill, line_addr(2, 12), '0, 1'b0, 1'b0, 2'd3, 1'b0, '0, 2'd1, '0};
    rows[7]  = '{op_fill, line_addr(3, 12), '0, 1'b0, 1'b0, 2'd3, 1'b0, '0, 2'd2, '0};
    rows[8]  = '{op_fill, line_addr(4, 12), '0, 1'b0, 1'b0, 2'd3, 1'b0, '0, 2'd3, '0};
    rows[9]  = '{op_fill, line_addr(5, 12), '0, 1'b0, 1'b0, 2'd3, 1'b0, '0, 2'd0, '0};
    rows[10] = '{op_fill, line_addr(1, 13), '0, 1'b0, 1'b0, 2'd3, 1'b0, '0, 2'd0, '0};
  end

  initial begin
    int    cycles;
    int    errors_before;
    word_t victim [LINE];
    word_t got_data;
    set_t  set_idx;
    addr_t victim_base;

    for (int a = 0; a < 4096; a++) mem[a] = pattern(a);
    for (int w = 0; w < 4; w++) begin
      for (int a = 0; a < 512; a++) data_mem[w][a] = 32'hd0000000 | (w << 12) | a;
      for (int s = 0; s < 32; s++) tag_mem[w][s] = 32'h00200000 | (w * 32 + s);  // valid, clean
    end
    repeat (8) @(negedge clk);
    rest = 1'b1;
    #10;
    check_word(word_t'({req_ready, bus_read, bus_write, data_ram_we, tag_ram_we}), '0,
               "outputs idle after reset");

    for (int t = 0; t < ROWS && !timed_out; t++) begin
      errors_before = errors;
      set_idx = rows[t].address[10:6];
      @(negedge clk);
      if (rows[t].preset) begin
        tag_mem[rows[t].exp_way][set_idx] = 32'h00600000 | rows[t].preset_tag;
        for (int i = 0; i < LINE; i++) victim[i] = data_mem[rows[t].exp_way][set_idx * LINE + i];
      end
      we_count = 0;
      wr_count = 0;
      burst_starts = 0;
      start_pos = -1;
      way_mixed = 1'b0;
      req_op = rows[t].op;
      req_address = rows[t].address;
      req_wdata = rows[t].wdata;
      req_read = rows[t].read;
      free_valid = rows[t].free_valid;
      free_way = rows[t].free_way;
      wait_ready(2000, cycles);
      got_data = rsp_data;
      @(negedge clk);
      req_op = op_none;
      if (timed_out) begin
        $display("test %0d timed out: req_ready never came", t);
      end else begin
        case (rows[t].op)
          op_init: begin
            check_word(word_t'(cycles), word_t'(130), "init latency in cycles");
            for (int w = 0; w < 4; w++) begin
              for (int s = 0; s < 32; s++) check_tag(tag_mem[w][s], '0, "entry after init");
            end
          end
          op_io: begin
            if (rows[t].read) check_word(got_data, rows[t].exp_data, "I/O read data");
            else check_word(mem[rows[t].address[13:2]], rows[t].exp_data, "I/O write to memory");
          end
          default: begin
            check_way(seen_way, rows[t].exp_way, "fill way");
            check_word(word_t'(we_count), word_t'(LINE), "data-RAM writes");
            if (way_mixed) begin
              $display("test %0d: data-RAM writes did not all use one way", t);
              errors++;
            end
            for (int i = 0; i < LINE; i++) begin
              check_word(data_mem[rows[t].exp_way][set_idx * LINE + i],
                         pattern(int'(rows[t].address[13:2]) + i), "filled line word");
            end
            check_tag(tag_mem[rows[t].exp_way][set_idx],
                      word_t'({1'b0, 1'b1, rows[t].address[31:11]}), "tag after fill");
            if (rows[t].preset) begin
              check_word(word_t'(wr_count), word_t'(LINE), "write-back commands");
              // only the first write of the line opens the burst
              check_word(word_t'(burst_starts), word_t'(1), "begin-burst flags");
              check_word(word_t'(start_pos), '0, "begin-burst position");
              victim_base = line_addr(rows[t].preset_tag, set_idx);
              for (int i = 0; i < LINE; i++) begin
                check_word(mem[victim_base[13:2] + i], victim[i], "written-back word");
              end
            end else begin
              check_word(word_t'(wr_count), '0, "bus writes for a clean victim");
            end
          end
        endcase
        if (errors == errors_before) passed++;
        $display("test %0d %s: %s", t, rows[t].op.name(),
                 (errors == errors_before) ? "ok" : "failed");
      end
    end

    $display("tests %0d, passed %0d, errors %0d", ROWS, passed, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
